// ==== Bender.yml ====
package:
  name: bus_layer

export_include_dirs:
  - logic

sources:
  - logic/bus_layer_pkg.sv
  - logic/bus_frame_if.sv
  - logic/frame_decoder.sv
  - logic/ctrl_channel_exec.sv
  - logic/rx_result_stage.sv
  - logic/tx_serializer.sv
  - logic/bus_layer_top.sv
  - target: test
    files:
      - dv/bus_layer_checker.sv
      - dv/bus_layer_tb.sv

// ==== bus_layer_top.f ====
+incdir+logic
logic/bus_layer_pkg.sv
logic/bus_frame_if.sv
logic/frame_decoder.sv
logic/ctrl_channel_exec.sv
logic/rx_result_stage.sv
logic/tx_serializer.sv
logic/bus_layer_top.sv
dv/bus_layer_checker.sv
dv/bus_layer_tb.sv

// ==== dv/bus_layer_checker.sv ====
// Concurrent assertions on the top-level handshakes and reset values of the
// bus layer. The testbench binds it into bus_layer_top and reads its count.
`timescale 1ns/1ps
`default_nettype none

module bus_layer_checker
(
	input  logic CLK_EXT,
	input  logic RESETn_local,
	input  logic RX_REQ,
	input  logic RX_ACK,
	input  logic [31:0] RX_DATA,
	input  logic TX_REQ,
	input  logic TX_ACK,
	input  logic CLKOUT,
	input  logic DOUT
);

	int assert_failures;

	initial
		assert_failures = 0;

	// a frame offered to the host stays put until the host acknowledges it.
	rx_req_holds: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		(RX_REQ && !RX_ACK) |=> (RX_REQ && $stable(RX_DATA)))
	else
	begin
		assert_failures++;
		$error("RX_REQ dropped or RX_DATA moved before RX_ACK");
	end

	tx_ack_after_req: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		$rose(TX_ACK) |-> $past(TX_REQ))
	else
	begin
		assert_failures++;
		$error("TX_ACK rose without TX_REQ");
	end

	// The bus lines idle high, so a layer in reset must not pull them low.
	reset_bus_high: assert property (@(posedge CLK_EXT) !RESETn_local |-> (CLKOUT && DOUT))
	else
	begin
		assert_failures++;
		$error("CLKOUT or DOUT low during reset");
	end

endmodule

`default_nettype wire

// ==== dv/bus_layer_tb.sv ====
// Directed testbench for the serial-bus layer. It drives frames on CLKIN/DIN,
// plays the host on both handshakes and checks delivery, control commands,
// failures, transmit and forwarding. Compile it with the project file list.
`timescale 1ns/1ps
`default_nettype none

`include "bus_layer_defs.svh"

module bus_layer_tb;

	localparam int CYCLE_LIMIT = 12000; // about 25 frames of 340 cycles plus margin.
	localparam logic [7:0] CTRL_ADDR = {`BUS_BCAST_PREFIX, `BUS_CTRL_FUNC};

	logic CLK_EXT;
	logic RESETn_local;
	logic MASTER_EN;
	logic CLKIN;
	logic DIN;
	logic CLKOUT;
	logic DOUT;
	logic [7:0] TX_ADDR;
	logic [31:0] TX_DATA;
	logic TX_REQ;
	logic TX_ACK;
	logic TX_SUCC;
	logic [7:0] RX_ADDR;
	logic [31:0] RX_DATA;
	logic RX_REQ;
	logic RX_ACK;
	logic RX_BROADCAST;
	logic RX_FAIL;

	int error_count;
	int test_errors;
	int test_count;
	int cycle_count;
	int rx_req_count;
	int rx_fail_count;
	int tx_succ_count;
	int tx_bit_count;
	string test_name;
	logic [7:0] seen_addr;
	logic [31:0] seen_data;
	logic seen_bcast;
	logic rx_req_prev;
	logic clkout_prev;
	logic ack_enable;
	logic tx_capture;
	logic [`BUS_FRAME_BITS-1:0] tx_bits;
	logic [31:0] lfsr_state;

	bus_layer_top u_bus_layer_top (.*);

	bind bus_layer_top bus_layer_checker u_bus_layer_checker (.*);

	always #2 CLK_EXT = ~CLK_EXT;

	always @(posedge CLK_EXT)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// host side of the receive handshake. Ack simply follows req when enabled.
	always @(posedge CLK_EXT)
	begin
		#1;
		RX_ACK = ack_enable && RX_REQ;
	end

	// Outputs are observed at the falling edge, half a cycle after they settle.
	always @(negedge CLK_EXT)
	begin
		if (RX_REQ && !rx_req_prev)
		begin
			rx_req_count++;
			seen_addr = RX_ADDR;
			seen_data = RX_DATA;
			seen_bcast = RX_BROADCAST;
		end
		if (RX_FAIL)
			rx_fail_count++; // one count per pulse cycle.
		if (TX_SUCC)
			tx_succ_count++;
		if (tx_capture && CLKOUT && !clkout_prev)
		begin
			tx_bits = {tx_bits[`BUS_FRAME_BITS-2:0], DOUT};
			tx_bit_count++;
		end
		rx_req_prev = RX_REQ;
		clkout_prev = CLKOUT;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1.
	endfunction

	// takes count bits from the LFSR into the low end of value.
	task automatic random_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n)
		begin
			@(posedge CLK_EXT);
			#1;
		end
	endtask

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	task automatic note_failure(input string text);
		$display("%s: %s", test_name, text);
		error_count++;
		test_errors++;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
		test_count++;
	endtask

	task automatic finish_test();
		$display("test %s: %s", test_name, (test_errors == 0) ? "passed" : "failed");
	endtask

	task automatic apply_reset(input logic master);
		RESETn_local = 1'b0;
		MASTER_EN = master;
		wait_cycles(3);
		RESETn_local = 1'b1;
		wait_cycles(2);
	endtask

	// each bit is 4 cycles low then 4 high, and 16 idle cycles close the frame.
	task automatic send_bits(input logic [`BUS_FRAME_BITS-1:0] bits, input int count);
		for (int i = count - 1; i >= 0; i--)
		begin
			CLKIN = 1'b0;
			DIN = bits[i];
			wait_cycles(4);
			CLKIN = 1'b1;
			wait_cycles(4);
		end
		DIN = 1'b1;
		wait_cycles(16);
	endtask

	task automatic send_frame(input logic [7:0] addr, input logic [31:0] data);
		send_bits({addr, data}, `BUS_FRAME_BITS);
	endtask

	task automatic wait_counts(input int req_target, input int fail_target);
		int waited;
		waited = 0;
		while (((rx_req_count < req_target) || (rx_fail_count < fail_target)) && (waited < 48))
		begin
			wait_cycles(1);
			waited++;
		end
		if ((rx_req_count < req_target) || (rx_fail_count < fail_target))
			note_failure("an expected RX_REQ or RX_FAIL never came");
	endtask

	task automatic enumerate_and_unicast();
		logic [31:0] data_other;
		logic [31:0] data_own;
		int req_base;
		start_test("enumeration and unicast");
		random_bits(32, data_other);
		random_bits(32, data_own);
		req_base = rx_req_count;
		send_frame(CTRL_ADDR, {4'h2, 24'h0, 4'h5}); // enumerate as short address 5.
		send_frame(8'h63, data_other);
		send_frame(8'h5A, data_own);
		wait_counts(req_base + 1, 0);
		wait_cycles(8);
		check_value("deliveries", 1, rx_req_count - req_base);
		check_value("rx address", 8'h5A, seen_addr);
		check_value("rx data", data_own, seen_data);
		check_value("rx broadcast", 1'b0, seen_bcast);
		finish_test();
	endtask

	task automatic broadcast_and_control();
		logic [31:0] data;
		int req_base;
		start_test("broadcast and control absorption");
		random_bits(32, data);
		req_base = rx_req_count;
		send_frame(8'hF4, data);
		wait_counts(req_base + 1, 0);
		check_value("rx address", 8'hF4, seen_addr);
		check_value("rx data", data, seen_data);
		check_value("rx broadcast", 1'b1, seen_bcast);
		req_base = rx_req_count;
		send_frame(CTRL_ADDR, {4'h9, 28'h0}); // an unknown command is absorbed.
		wait_cycles(8);
		check_value("control deliveries", 0, rx_req_count - req_base);
		finish_test();
	endtask

	task automatic invalidate_and_master();
		logic [31:0] data;
		int req_base;
		start_test("invalidate and master mode");
		random_bits(32, data);
		send_frame(CTRL_ADDR, {4'h3, 28'h0});
		req_base = rx_req_count;
		send_frame(8'h5A, data);
		wait_cycles(8);
		check_value("unicast after invalidate", 0, rx_req_count - req_base);
		send_frame(8'hF7, data);
		wait_counts(req_base + 1, 0);
		check_value("broadcast address", 8'hF7, seen_addr);
		apply_reset(1'b1);
		random_bits(32, data);
		req_base = rx_req_count;
		send_frame({`BUS_MASTER_ADDR, 4'h2}, data);
		wait_counts(req_base + 1, 0);
		check_value("master unicast data", data, seen_data);
		send_frame(CTRL_ADDR, {4'h2, 24'h0, 4'h7}); // a master ignores this.
		req_base = rx_req_count;
		send_frame(8'h7C, data);
		wait_cycles(8);
		check_value("prefix 7 deliveries", 0, rx_req_count - req_base);
		finish_test();
	endtask

	task automatic receive_failures();
		logic [31:0] data_a;
		logic [31:0] data_b;
		int req_base;
		int fail_base;
		int waited;
		start_test("receive failures");
		random_bits(32, data_a);
		random_bits(32, data_b);
		req_base = rx_req_count;
		fail_base = rx_fail_count;
		send_bits({8'h00, data_a}, 23);
		wait_counts(req_base, fail_base + 1);
		wait_cycles(8);
		check_value("short frame fail pulses", 1, rx_fail_count - fail_base);
		check_value("short frame deliveries", 0, rx_req_count - req_base);
		ack_enable = 1'b0;
		fail_base = rx_fail_count;
		send_frame(8'hF5, data_a);
		send_frame(8'hF6, data_b);
		wait_counts(req_base + 1, fail_base + 1);
		check_value("overrun deliveries", 1, rx_req_count - req_base);
		check_value("overrun fail pulses", 1, rx_fail_count - fail_base);
		check_value("held address", 8'hF5, seen_addr);
		check_value("held data", data_a, RX_DATA);
		ack_enable = 1'b1;
		waited = 0;
		while ((RX_REQ || RX_ACK) && (waited < 16))
		begin
			wait_cycles(1);
			waited++;
		end
		if (RX_REQ || RX_ACK)
			note_failure("the receive handshake did not return to idle");
		finish_test();
	endtask

	task automatic transmit_frame();
		logic [31:0] data;
		logic [31:0] addr_bits;
		int succ_base;
		int waited;
		start_test("transmit");
		random_bits(32, data);
		random_bits(8, addr_bits);
		tx_bits = '0;
		tx_bit_count = 0;
		succ_base = tx_succ_count;
		tx_capture = 1'b1;
		TX_ADDR = addr_bits[7:0];
		TX_DATA = data;
		TX_REQ = 1'b1;
		waited = 0;
		while (!TX_ACK && (waited < 16))
		begin
			wait_cycles(1);
			waited++;
		end
		if (!TX_ACK)
			note_failure("TX_ACK did not rise after TX_REQ");
		TX_REQ = 1'b0;
		waited = 0;
		while ((tx_succ_count == succ_base) && (waited < 400))
		begin
			wait_cycles(1);
			waited++;
		end
		if (tx_succ_count == succ_base)
			note_failure("TX_SUCC never pulsed after the frame");
		wait_cycles(8);
		tx_capture = 1'b0;
		check_value("clock rises", `BUS_FRAME_BITS, tx_bit_count);
		check_value("sent bits", {addr_bits[7:0], data}, tx_bits);
		check_value("tx_succ cycles", 1, tx_succ_count - succ_base);
		check_value("tx_ack at end", 1'b0, TX_ACK);
		finish_test();
	endtask

	task automatic forward_idle_bus();
		logic [31:0] pattern;
		logic clk_last;
		logic din_last;
		start_test("forwarding");
		random_bits(32, pattern);
		clk_last = CLKIN;
		din_last = DIN;
		for (int i = 0; i < 16; i++)
		begin
			CLKIN = pattern[2*i+1];
			DIN = pattern[2*i];
			#1; // the new inputs are applied, so the outputs must still show the old ones.
			check_value("forwarded clock", clk_last, CLKOUT);
			check_value("forwarded data", din_last, DOUT);
			clk_last = pattern[2*i+1];
			din_last = pattern[2*i];
			wait_cycles(1);
		end
		CLKIN = 1'b1;
		DIN = 1'b1;
		wait_cycles(24); // lets the decoder close whatever the pattern started.
		finish_test();
	endtask

	initial
	begin
		CLK_EXT = 1'b0;
		RESETn_local = 1'b1;
		MASTER_EN = 1'b0;
		CLKIN = 1'b1;
		DIN = 1'b1;
		TX_ADDR = '0;
		TX_DATA = '0;
		TX_REQ = 1'b0;
		RX_ACK = 1'b0;
		lfsr_state = 32'hb715;
		error_count = 0;
		test_count = 0;
		cycle_count = 0;
		rx_req_count = 0;
		rx_fail_count = 0;
		tx_succ_count = 0;
		tx_bit_count = 0;
		rx_req_prev = 1'b0;
		clkout_prev = 1'b1;
		ack_enable = 1'b1;
		tx_capture = 1'b0;
		#1;
		apply_reset(1'b0);
		enumerate_and_unicast();
		broadcast_and_control();
		invalidate_and_master();
		receive_failures();
		transmit_frame();
		forward_idle_bus();
		if (u_bus_layer_top.u_bus_layer_checker.assert_failures != 0)
		begin
			$display("the bound checker saw %0d assertion failures",
				u_bus_layer_top.u_bus_layer_checker.assert_failures);
			error_count += u_bus_layer_top.u_bus_layer_checker.assert_failures;
		end
		$display("summary: %0d tests run, %0d failures", test_count, error_count);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/bus_frame_if.sv ====
// Carries one decoded frame from the frame decoder to its consumers.
// Valid and bad are single-cycle pulses and the payload is held with them.
`timescale 1ns/1ps
`default_nettype none

interface bus_frame_if;

	logic frame_valid; // accepted frame, one cycle.
	bus_layer_pkg::frame_kind_e frame_kind;
	bus_layer_pkg::bus_addr_t frame_addr;
	logic [31:0] frame_data;
	logic frame_bad; // frame closed with a wrong bit count.

	modport decoder (output frame_valid, frame_kind, frame_addr, frame_data, frame_bad);

	// the control executor only looks at control frames and their data.
	modport exec (input frame_valid, frame_kind, frame_data);

	modport result (input frame_valid, frame_kind, frame_addr, frame_data, frame_bad);

endinterface

`default_nettype wire

// ==== logic/bus_layer_defs.svh ====
// Frame length, bus timing and fixed address constants of the bus layer.
// Include this header in any RTL file that needs one of these values.
`ifndef BUS_LAYER_DEFS_SVH
`define BUS_LAYER_DEFS_SVH

// a frame is 8 address bits followed by 32 data bits.
`define BUS_FRAME_BITS 40

// CLK_EXT cycles of CLKIN high that close a frame.
`define BUS_IDLE_CYCLES 12

// CLK_EXT cycles per transmitted bit. The clock is low for the first half.
`define BUS_BIT_CYCLES 4

`define BUS_MASTER_ADDR 4'h1 // short address used in master mode.
`define BUS_BCAST_PREFIX 4'hF // prefix shared by all broadcast frames.
`define BUS_CTRL_FUNC 4'h0 // broadcast function of the control channel.

`endif

// ==== logic/bus_layer_pkg.sv ====
// Types shared by the bus layer modules.
// Refer to them by scoped name, for example bus_layer_pkg::bus_addr_t.
`default_nettype none

package bus_layer_pkg;

	// address byte of a frame, sent first on the bus.
	typedef struct packed
	{
		logic [3:0] prefix; // short prefix, or the broadcast prefix.
		logic [3:0] func; // function, or channel for broadcasts.
	} bus_addr_t;

	// how the decoder classified an accepted frame.
	typedef enum logic [1:0]
	{
		FRAME_UNICAST = 2'd0,
		FRAME_BROADCAST = 2'd1,
		FRAME_CONTROL = 2'd2
	} frame_kind_e;

	// Command field of a control-channel frame, held in data bits 31..28.
	// Values not listed here are ignored by the layer.
	typedef enum logic [3:0]
	{
		CMD_SET_ADDR = 4'h2, // new short address in data bits 3..0.
		CMD_INVALIDATE = 4'h3
	} ctrl_cmd_e;

endpackage

`default_nettype wire

// ==== logic/bus_layer_top.sv ====
// Top level of the serial-bus layer interface. It joins the frame decoder,
// the control-channel executor, the receive result stage and the transmit
// serializer. Only wiring lives here.
`timescale 1ns/1ps
`default_nettype none

module bus_layer_top
(
	input  logic CLK_EXT,
	input  logic RESETn_local,
	input  logic MASTER_EN,
	input  logic CLKIN,
	input  logic DIN,
	output logic CLKOUT,
	output logic DOUT,
	input  logic [7:0] TX_ADDR,
	input  logic [31:0] TX_DATA,
	input  logic TX_REQ,
	output logic TX_ACK,
	output logic TX_SUCC,
	output logic [7:0] RX_ADDR,
	output logic [31:0] RX_DATA,
	output logic RX_REQ,
	input  logic RX_ACK,
	output logic RX_BROADCAST,
	output logic RX_FAIL
);

	logic [3:0] own_addr;
	logic own_addr_valid;

	bus_frame_if frame_bus ();

	frame_decoder u_frame_decoder
	(
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.clkin(CLKIN),
		.din(DIN),
		.own_addr(own_addr),
		.own_addr_valid(own_addr_valid),
		.frame(frame_bus)
	);

	ctrl_channel_exec u_ctrl_channel_exec
	(
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.master_en(MASTER_EN),
		.frame(frame_bus),
		.own_addr(own_addr),
		.own_addr_valid(own_addr_valid)
	);

	rx_result_stage u_rx_result_stage
	(
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.frame(frame_bus),
		.rx_addr(RX_ADDR),
		.rx_data(RX_DATA),
		.rx_req(RX_REQ),
		.rx_ack(RX_ACK),
		.rx_broadcast(RX_BROADCAST),
		.rx_fail(RX_FAIL)
	);

	tx_serializer u_tx_serializer
	(
		.CLK_EXT(CLK_EXT),
		.RESETn_local(RESETn_local),
		.clkin(CLKIN),
		.din(DIN),
		.tx_addr(TX_ADDR),
		.tx_data(TX_DATA),
		.tx_req(TX_REQ),
		.tx_ack(TX_ACK),
		.tx_succ(TX_SUCC),
		.clkout(CLKOUT),
		.dout(DOUT)
	);

endmodule

`default_nettype wire

// ==== logic/ctrl_channel_exec.sv ====
// Address register of the bus layer. It executes the control-channel
// commands that set and invalidate the short address, and presents the
// fixed master address instead when master mode is on.
`timescale 1ns/1ps
`default_nettype none

`include "bus_layer_defs.svh"

module ctrl_channel_exec
(
	input  logic CLK_EXT,
	input  logic RESETn_local,
	input  logic master_en,
	bus_frame_if.exec frame,
	output logic [3:0] own_addr,
	output logic own_addr_valid
);

	logic [3:0] addr_q;
	logic addr_valid_q;
	logic ctrl_hit;
	logic [3:0] cmd;

	// a master never takes commands from the control channel.
	assign ctrl_hit = frame.frame_valid && !master_en &&
		(frame.frame_kind == bus_layer_pkg::FRAME_CONTROL);
	assign cmd = frame.frame_data[31:28];

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			addr_q <= 4'h0;
			addr_valid_q <= 1'b0;
		end
		else if (ctrl_hit)
		begin
			case (cmd)
				bus_layer_pkg::CMD_SET_ADDR:
				begin
					// Enumeration only assigns a layer that has no address yet,
					// so a repeated command does not move an enumerated layer.
					if (!addr_valid_q)
					begin
						addr_q <= frame.frame_data[3:0];
						addr_valid_q <= 1'b1;
					end
				end
				bus_layer_pkg::CMD_INVALIDATE:
				begin
					addr_q <= 4'h0;
					addr_valid_q <= 1'b0;
				end
				default: ; // unknown commands are absorbed without effect.
			endcase
		end
	end

	assign own_addr = master_en ? `BUS_MASTER_ADDR : addr_q;
	assign own_addr_valid = master_en || addr_valid_q;

endmodule

`default_nettype wire

// ==== logic/frame_decoder.sv ====
// Receive side of the bus layer. It synchronizes CLKIN and DIN, takes a bit
// on every clock rise and closes the frame after a long enough idle high.
// Accepted frames are classified and presented on the frame interface.
`timescale 1ns/1ps
`default_nettype none

`include "bus_layer_defs.svh"

module frame_decoder
(
	input  logic CLK_EXT,
	input  logic RESETn_local,
	input  logic clkin,
	input  logic din,
	input  logic [3:0] own_addr,
	input  logic own_addr_valid,
	bus_frame_if.decoder frame
);

	localparam int FRAME_BITS = `BUS_FRAME_BITS;
	localparam int IDLE_CYCLES = `BUS_IDLE_CYCLES;
	localparam int IDLE_W = $clog2(IDLE_CYCLES + 1);

	logic clk_s1, clk_s2, clk_prev;
	logic din_s1, din_s2;
	logic clk_rise;
	logic [FRAME_BITS-1:0] shift_q;
	logic [5:0] bit_cnt;
	logic [IDLE_W-1:0] idle_cnt;
	logic frame_end;
	bus_layer_pkg::bus_addr_t rx_addr;
	bus_layer_pkg::frame_kind_e rx_kind;
	logic rx_accept;

	// the idle bus is high, so the synchronizer comes out of reset high.
	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			clk_s1 <= 1'b1;
			clk_s2 <= 1'b1;
			clk_prev <= 1'b1;
			din_s1 <= 1'b1;
			din_s2 <= 1'b1;
		end
		else
		begin
			clk_s1 <= clkin;
			clk_s2 <= clk_s1;
			clk_prev <= clk_s2;
			din_s1 <= din;
			din_s2 <= din_s1;
		end
	end

	assign clk_rise = clk_s2 && !clk_prev;
	assign frame_end = clk_s2 && (idle_cnt == IDLE_W'(IDLE_CYCLES - 1));

	// Address classification. Only frames this layer must see are accepted;
	// unicast frames to any other prefix are dropped here without a trace.
	assign rx_addr = shift_q[FRAME_BITS-1 -: 8];

	always_comb
	begin
		rx_kind = bus_layer_pkg::FRAME_UNICAST;
		rx_accept = 1'b0;
		if (rx_addr.prefix == `BUS_BCAST_PREFIX)
		begin
			rx_accept = 1'b1;
			if (rx_addr.func == `BUS_CTRL_FUNC)
				rx_kind = bus_layer_pkg::FRAME_CONTROL;
			else
				rx_kind = bus_layer_pkg::FRAME_BROADCAST;
		end
		else if (own_addr_valid && (rx_addr.prefix == own_addr))
			rx_accept = 1'b1;
	end

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			bit_cnt <= '0;
			idle_cnt <= '0;
			frame.frame_valid <= 1'b0;
			frame.frame_bad <= 1'b0;
		end
		else
		begin
			frame.frame_valid <= 1'b0;
			frame.frame_bad <= 1'b0;
			if (!clk_s2)
				idle_cnt <= '0;
			else if (idle_cnt != IDLE_W'(IDLE_CYCLES))
				idle_cnt <= idle_cnt + 1'b1; // stops at the limit so a frame ends once.
			if (frame_end)
			begin
				bit_cnt <= '0;
				if (bit_cnt == 6'(FRAME_BITS))
					frame.frame_valid <= rx_accept;
				else if (bit_cnt != '0)
					frame.frame_bad <= 1'b1;
			end
			else if (clk_rise && (bit_cnt != '1))
				bit_cnt <= bit_cnt + 1'b1; // saturates, so long frames still count as bad.
		end
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (clk_rise)
			shift_q <= {shift_q[FRAME_BITS-2:0], din_s2}; // MSB arrives first.
		if (frame_end)
		begin
			frame.frame_kind <= rx_kind;
			frame.frame_addr <= rx_addr;
			frame.frame_data <= shift_q[FRAME_BITS-9:0];
		end
	end

endmodule

`default_nettype wire

// ==== logic/rx_result_stage.sv ====
// Holds a received unicast or broadcast frame for the host and runs the
// RX_REQ/RX_ACK level handshake. A frame that finds the stage busy is
// dropped, and that and every bad frame give a one-cycle RX_FAIL.
`timescale 1ns/1ps
`default_nettype none

module rx_result_stage
(
	input  logic CLK_EXT,
	input  logic RESETn_local,
	bus_frame_if.result frame,
	output logic [7:0] rx_addr,
	output logic [31:0] rx_data,
	output logic rx_req,
	input  logic rx_ack,
	output logic rx_broadcast,
	output logic rx_fail
);

	logic data_frame;
	logic busy;

	// control frames stay inside the layer.
	assign data_frame = frame.frame_valid &&
		(frame.frame_kind != bus_layer_pkg::FRAME_CONTROL);

	// the host still holds ack high until it sees req fall.
	assign busy = rx_req || rx_ack;

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			rx_req <= 1'b0;
			rx_broadcast <= 1'b0;
			rx_fail <= 1'b0;
		end
		else
		begin
			rx_fail <= frame.frame_bad || (data_frame && busy);
			if (rx_req && rx_ack)
				rx_req <= 1'b0; // host took the frame.
			else if (data_frame && !busy)
			begin
				rx_req <= 1'b1;
				rx_broadcast <= (frame.frame_kind == bus_layer_pkg::FRAME_BROADCAST);
			end
		end
	end

	// holding registers, loaded only when the host side is free.
	always_ff @(posedge CLK_EXT)
	begin
		if (data_frame && !busy)
		begin
			rx_addr <= frame.frame_addr;
			rx_data <= frame.frame_data;
		end
	end

endmodule

`default_nettype wire

// ==== logic/tx_serializer.sv ====
// Transmit side of the bus layer. A host frame taken over TX_REQ/TX_ACK is
// shifted out MSB first on CLKOUT/DOUT, followed by an idle high tail and a
// TX_SUCC pulse. While idle the incoming bus is passed on one cycle late.
`timescale 1ns/1ps
`default_nettype none

`include "bus_layer_defs.svh"

module tx_serializer
(
	input  logic CLK_EXT,
	input  logic RESETn_local,
	input  logic clkin,
	input  logic din,
	input  logic [7:0] tx_addr,
	input  logic [31:0] tx_data,
	input  logic tx_req,
	output logic tx_ack,
	output logic tx_succ,
	output logic clkout,
	output logic dout
);

	localparam int FRAME_BITS = `BUS_FRAME_BITS;
	localparam int BIT_CYCLES = `BUS_BIT_CYCLES;
	localparam int IDLE_CYCLES = `BUS_IDLE_CYCLES;
	localparam int CNT_W = $clog2((IDLE_CYCLES > BIT_CYCLES) ? IDLE_CYCLES : BIT_CYCLES);

	typedef enum logic [1:0]
	{
		IDLE,
		SEND,
		TAIL,
		DONE
	} tx_state_e;

	tx_state_e state;
	logic [FRAME_BITS-1:0] shift_q;
	logic [5:0] bit_cnt;
	logic [CNT_W-1:0] phase_cnt; // bit phase in SEND, tail length in TAIL.
	logic clk_fwd_q, din_fwd_q;

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			state <= IDLE;
			bit_cnt <= '0;
			phase_cnt <= '0;
			tx_ack <= 1'b0;
			clk_fwd_q <= 1'b1;
			din_fwd_q <= 1'b1;
		end
		else
		begin
			clk_fwd_q <= clkin;
			din_fwd_q <= din;
			if (tx_ack && !tx_req)
				tx_ack <= 1'b0;
			case (state)
				IDLE:
				begin
					if (tx_req && !tx_ack)
					begin
						tx_ack <= 1'b1;
						bit_cnt <= '0;
						phase_cnt <= '0;
						state <= SEND;
					end
				end
				SEND:
				begin
					if (phase_cnt == CNT_W'(BIT_CYCLES - 1))
					begin
						phase_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 6'(FRAME_BITS - 1))
							state <= TAIL;
					end
					else
						phase_cnt <= phase_cnt + 1'b1;
				end
				TAIL:
				begin
					if (phase_cnt == CNT_W'(IDLE_CYCLES - 1))
						state <= DONE;
					else
						phase_cnt <= phase_cnt + 1'b1;
				end
				default: state <= IDLE; // DONE lasts one cycle.
			endcase
		end
	end

	// the frame is loaded on the accepting cycle and moves on each bit end.
	always_ff @(posedge CLK_EXT)
	begin
		if ((state == IDLE) && tx_req && !tx_ack)
			shift_q <= {tx_addr, tx_data};
		else if ((state == SEND) && (phase_cnt == CNT_W'(BIT_CYCLES - 1)))
			shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
	end

	always_comb
	begin
		case (state)
			SEND:
			begin
				clkout = (phase_cnt >= CNT_W'(BIT_CYCLES / 2));
				dout = shift_q[FRAME_BITS-1];
			end
			TAIL:
			begin
				clkout = 1'b1;
				dout = 1'b1;
			end
			default:
			begin
				clkout = clk_fwd_q; // pass the bus on when not sending.
				dout = din_fwd_q;
			end
		endcase
	end

	assign tx_succ = (state == DONE);

endmodule

`default_nettype wire
